/* build.f */
+incdir+testbench
hw/core_pkg.sv
hw/mem_bus_pkg.sv
hw/state_sequencer.sv
hw/mem_port.sv
hw/fetch_unit.sv
hw/operand_unit.sv
hw/alu.sv
hw/retire_unit.sv
hw/internal_bus.sv
testbench/tb_clock_gen.sv
testbench/tb_internal_bus.sv

/* hw/alu.sv */
`timescale 1ns/1ps

module alu (
  input  logic                          clk,
  input  core_pkg::core_state_t         state,
  input  core_pkg::command_t            command,
  input  logic [mem_bus_pkg::DATA_W-1:0] src1_val,
  input  logic [mem_bus_pkg::DATA_W-1:0] src0_val,
  output logic [mem_bus_pkg::DATA_W-1:0] result_lo,
  output logic [mem_bus_pkg::DATA_W-1:0] result_hi,
  output logic                          cond
);
  import core_pkg::*;
  import mem_bus_pkg::*;

  logic [2*DATA_W-1:0] product;
  logic [DATA_W-1:0]   lo_next;
  logic [DATA_W-1:0]   hi_next;

  // unsigned full width product
  assign product = src1_val * src0_val;

  always_comb begin
    hi_next = '0;
    case (command.reg_form.opcode)
      op_add, op_addi: lo_next = src1_val + src0_val;
      op_sub: lo_next = src1_val - src0_val;
      op_and: lo_next = src1_val & src0_val;
      op_xor: lo_next = src1_val ^ src0_val;
      op_mul: begin
        lo_next = product[DATA_W-1:0];
        hi_next = product[2*DATA_W-1:DATA_W];
      end
      default: lo_next = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (state == st_execute) begin
      result_lo <= lo_next;
      result_hi <= hi_next;
      cond      <= (src1_val != '0);
    end
  end

endmodule

/* hw/core_pkg.sv */
package core_pkg;

  // one state per phase of a command
  typedef enum logic [2:0] {
    st_fetch,
    st_read,
    st_execute,
    st_write,
    st_write_h,
    st_retire,
    st_halted
  } core_state_t;

  // codes 8 to 15 are unused and run as a no-op
  typedef enum logic [3:0] {
    op_add,
    op_sub,
    op_and,
    op_xor,
    op_addi,
    op_mul,
    op_bnz,
    op_halt
  } opcode_t;

  typedef struct packed {
    opcode_t     opcode;
    logic [9:0]  dst;
    logic [8:0]  src1;
    logic [8:0]  src0;
  } cmd_reg_t;

  // immediate form, only op_addi reads it this way
  typedef struct packed {
    opcode_t           opcode;
    logic [9:0]        dst;
    logic [8:0]        src1;
    logic signed [8:0] imm;
  } cmd_imm_t;

  typedef union packed {
    cmd_reg_t reg_form;
    cmd_imm_t imm_form;
  } command_t;

endpackage

/* hw/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit (
  input  logic                          clk,
  input  logic                          rst,
  input  core_pkg::core_state_t         state,
  input  logic [mem_bus_pkg::ADDR_W-1:0] pc,
  input  logic                          can_issue,
  input  mem_bus_pkg::mem_rsp_t         mem_rsp,
  output mem_bus_pkg::mem_req_t         fetch_req,
  output core_pkg::command_t            command,
  output logic                          step_done
);
  import core_pkg::*;
  import mem_bus_pkg::*;

  logic in_fetch;
  logic pending;
  logic armed;

  assign in_fetch = (state == st_fetch);

  always_comb begin
    fetch_req       = '0;
    fetch_req.valid = in_fetch & armed & ~pending;
    fetch_req.addr  = pc;
  end

  // nothing else is in flight during fetch
  assign step_done = in_fetch & mem_rsp.valid;

  always_ff @(posedge clk) begin
    if (rst) begin
      pending <= 1'b0;
      armed   <= 1'b0;
    end else begin
      armed <= 1'b1;
      if (step_done) begin
        pending <= 1'b0;
      end else if (fetch_req.valid && can_issue) begin
        pending <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (step_done) begin
      command <= command_t'(mem_rsp.rdata);
    end
  end

endmodule

/* hw/internal_bus.sv */
`timescale 1ns/1ps

module internal_bus #(
  parameter int          CREDITS  = 2,
  parameter int unsigned RESET_PC = 0
) (
  input  logic                           clk,
  input  logic                           rst,
  output mem_bus_pkg::mem_req_t          mem_req,
  input  mem_bus_pkg::mem_rsp_t          mem_rsp,
  output logic                           halted,
  output logic [mem_bus_pkg::ADDR_W-1:0] pc
);
  import core_pkg::*;
  import mem_bus_pkg::*;

  core_state_t       state;
  command_t          command;
  mem_req_t          fetch_req;
  mem_req_t          op_req;
  logic              can_issue;
  logic              fetch_done;
  logic              operand_done;
  logic [DATA_W-1:0] src1_val;
  logic [DATA_W-1:0] src0_val;
  logic [DATA_W-1:0] result_lo;
  logic [DATA_W-1:0] result_hi;
  logic              cond;

  // each unit signals done only in its own states
  state_sequencer seq0 (
    .clk       (clk),
    .rst       (rst),
    .command   (command),
    .step_done (fetch_done | operand_done),
    .state     (state),
    .halted    (halted)
  );

  mem_port #(.CREDITS(CREDITS)) port0 (
    .clk       (clk),
    .rst       (rst),
    .state     (state),
    .fetch_req (fetch_req),
    .op_req    (op_req),
    .mem_rsp   (mem_rsp),
    .mem_req   (mem_req),
    .can_issue (can_issue)
  );

  fetch_unit fetch0 (
    .clk       (clk),
    .rst       (rst),
    .state     (state),
    .pc        (pc),
    .can_issue (can_issue),
    .mem_rsp   (mem_rsp),
    .fetch_req (fetch_req),
    .command   (command),
    .step_done (fetch_done)
  );

  operand_unit #(.CREDITS(CREDITS)) operand0 (
    .clk       (clk),
    .rst       (rst),
    .state     (state),
    .command   (command),
    .can_issue (can_issue),
    .mem_rsp   (mem_rsp),
    .result_lo (result_lo),
    .result_hi (result_hi),
    .op_req    (op_req),
    .src1_val  (src1_val),
    .src0_val  (src0_val),
    .step_done (operand_done)
  );

  alu alu0 (
    .clk       (clk),
    .state     (state),
    .command   (command),
    .src1_val  (src1_val),
    .src0_val  (src0_val),
    .result_lo (result_lo),
    .result_hi (result_hi),
    .cond      (cond)
  );

  retire_unit #(.RESET_PC(RESET_PC)) retire0 (
    .clk     (clk),
    .rst     (rst),
    .state   (state),
    .command (command),
    .cond    (cond),
    .pc      (pc)
  );

endmodule

/* hw/mem_bus_pkg.sv */
package mem_bus_pkg;

  localparam int DATA_W = 32;
  localparam int ADDR_W = 10;

  // word addressed, one request per cycle at most
  typedef struct packed {
    logic              valid;
    logic              write;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } mem_req_t;

  // one response per request, in order; each returns a credit
  typedef struct packed {
    logic              valid;
    logic [DATA_W-1:0] rdata;
  } mem_rsp_t;

endpackage

/* hw/mem_port.sv */
`timescale 1ns/1ps

module mem_port #(
  parameter int CREDITS = 2
) (
  input  logic                   clk,
  input  logic                   rst,
  input  core_pkg::core_state_t  state,
  input  mem_bus_pkg::mem_req_t  fetch_req,
  input  mem_bus_pkg::mem_req_t  op_req,
  input  mem_bus_pkg::mem_rsp_t  mem_rsp,
  output mem_bus_pkg::mem_req_t  mem_req,
  output logic                   can_issue
);
  import core_pkg::*;
  import mem_bus_pkg::*;

  localparam int CNT_W = $clog2(CREDITS + 1);

  logic [CNT_W-1:0] credits;
  mem_req_t         sel_req;

  // only one unit talks to memory in any state
  assign sel_req   = (state == st_fetch) ? fetch_req : op_req;
  assign can_issue = (credits != '0);

  always_comb begin
    mem_req       = sel_req;
    mem_req.valid = sel_req.valid & can_issue;
  end

  // issue and response in the same cycle cancel out
  always_ff @(posedge clk) begin
    if (rst) begin
      credits <= CNT_W'(CREDITS);
    end else begin
      case ({mem_req.valid, mem_rsp.valid})
        2'b10: credits <= credits - 1'b1;
        2'b01: credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

endmodule

/* hw/operand_unit.sv */
`timescale 1ns/1ps

module operand_unit #(
  parameter int CREDITS = 2
) (
  input  logic                          clk,
  input  logic                          rst,
  input  core_pkg::core_state_t         state,
  input  core_pkg::command_t            command,
  input  logic                          can_issue,
  input  mem_bus_pkg::mem_rsp_t         mem_rsp,
  input  logic [mem_bus_pkg::DATA_W-1:0] result_lo,
  input  logic [mem_bus_pkg::DATA_W-1:0] result_hi,
  output mem_bus_pkg::mem_req_t         op_req,
  output logic [mem_bus_pkg::DATA_W-1:0] src1_val,
  output logic [mem_bus_pkg::DATA_W-1:0] src0_val,
  output logic                          step_done
);
  import core_pkg::*;
  import mem_bus_pkg::*;

  // never more than two reads per command
  localparam logic [1:0] WINDOW = (CREDITS < 2) ? 2'd1 : 2'd2;

  logic [1:0]        issued;
  logic [1:0]        received;
  logic [1:0]        needed;
  logic              active;
  logic              is_addi;
  logic              window_ok;
  logic [DATA_W-1:0] src0_q;

  assign is_addi   = (command.reg_form.opcode == op_addi);
  assign active    = state inside {st_read, st_write, st_write_h};
  assign needed    = (state == st_read && !is_addi) ? 2'd2 : 2'd1;
  assign window_ok = 2'(issued - received) < WINDOW;

  always_comb begin
    op_req       = '0;
    op_req.valid = active && (issued < needed) && window_ok;
    case (state)
      // src1 first, then src0
      st_read: begin
        op_req.addr = (issued == 2'd0) ? {1'b0, command.reg_form.src1}
                                       : {1'b0, command.reg_form.src0};
      end
      st_write: begin
        op_req.write = 1'b1;
        op_req.addr  = command.reg_form.dst;
        op_req.wdata = result_lo;
      end
      st_write_h: begin
        op_req.write = 1'b1;
        op_req.addr  = command.reg_form.dst + 1'b1;
        op_req.wdata = result_hi;
      end
      default: op_req.addr = '0;
    endcase
  end

  // last in-order response closes the state
  assign step_done = active && mem_rsp.valid && (received == needed - 2'd1);

  always_ff @(posedge clk) begin
    if (rst || step_done) begin
      issued   <= 2'd0;
      received <= 2'd0;
    end else begin
      if (op_req.valid && can_issue) issued <= issued + 2'd1;
      if (active && mem_rsp.valid) received <= received + 2'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_read && mem_rsp.valid) begin
      if (received == 2'd0) begin
        src1_val <= mem_rsp.rdata;
      end else begin
        src0_q <= mem_rsp.rdata;
      end
    end
  end

  // addi takes its second operand from the command word
  assign src0_val = is_addi ? {{(DATA_W-9){command.imm_form.imm[8]}}, command.imm_form.imm}
                            : src0_q;

endmodule

/* hw/retire_unit.sv */
`timescale 1ns/1ps

module retire_unit #(
  parameter int unsigned RESET_PC = 0
) (
  input  logic                           clk,
  input  logic                           rst,
  input  core_pkg::core_state_t          state,
  input  core_pkg::command_t             command,
  input  logic                           cond,
  output logic [mem_bus_pkg::ADDR_W-1:0] pc
);
  import core_pkg::*;
  import mem_bus_pkg::*;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= ADDR_W'(RESET_PC);
    end else if (state == st_retire) begin
      case (command.reg_form.opcode)
        op_bnz: pc <= cond ? command.reg_form.dst : pc + 1'b1;
        // halt leaves pc on itself
        op_halt: pc <= pc;
        default: pc <= pc + 1'b1;
      endcase
    end
  end

endmodule

/* hw/state_sequencer.sv */
`timescale 1ns/1ps

module state_sequencer (
  input  logic                  clk,
  input  logic                  rst,
  input  core_pkg::command_t    command,
  input  logic                  step_done,
  output core_pkg::core_state_t state,
  output logic                  halted
);
  import core_pkg::*;

  core_state_t next_state;
  opcode_t     opcode;

  assign opcode = command.reg_form.opcode;

  always_comb begin
    next_state = state;
    case (state)
      st_fetch: if (step_done) next_state = st_read;
      st_read: if (step_done) next_state = st_execute;
      st_execute: begin
        // bnz, halt and unused codes have nothing to store
        case (opcode)
          op_add, op_sub, op_and, op_xor, op_addi, op_mul: next_state = st_write;
          default: next_state = st_retire;
        endcase
      end
      st_write: if (step_done) next_state = (opcode == op_mul) ? st_write_h : st_retire;
      st_write_h: if (step_done) next_state = st_retire;
      st_retire: next_state = (opcode == op_halt) ? st_halted : st_fetch;
      st_halted: next_state = st_halted;
      default: next_state = st_fetch;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_fetch;
    end else begin
      state <= next_state;
    end
  end

  assign halted = (state == st_halted);

endmodule

/* run.sh */
#!/bin/sh
# compile with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
  verilator --binary --timing -Wno-fatal -f build.f --top-module tb_internal_bus -o tb_sim &&
  ./obj_dir/tb_sim | tee /dev/stderr | grep -qx "test passed" &&
  echo "simulation passed" ||
  { echo "simulation failed"; exit 1; }

/* testbench/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int RESET_CYCLES = 16
) (
  input  logic restart,
  output logic clk,
  output logic rst
);
  int   cycles;
  logic again;

  // 4 ns period; rst counts rising edges and moves 1 ns after the edge
  initial begin
    clk    = 1'b0;
    rst    = 1'b1;
    cycles = 0;
    forever begin
      #2 clk = 1'b1;
      again = restart;
      #1;
      if (again) begin
        cycles = 0;
      end else if (cycles < RESET_CYCLES) begin
        cycles = cycles + 1;
      end
      rst = (cycles < RESET_CYCLES);
      #1 clk = 1'b0;
    end
  end

endmodule

/* testbench/tb_tests.svh */
  opcode_t           alu_ops [4] = '{op_add, op_sub, op_and, op_xor};
  logic [DATA_W-1:0] opa [4];
  logic [DATA_W-1:0] opb [4];
  logic [DATA_W-1:0] first_run [4];

  function automatic logic [DATA_W-1:0] alu_expected(input int i);
    case (alu_ops[i])
      op_add: return opa[i] + opb[i];
      op_sub: return opa[i] - opb[i];
      op_and: return opa[i] & opb[i];
      default: return opa[i] ^ opb[i];
    endcase
  endfunction

  // operands from 300, results from 600, halt after four commands
  task automatic load_alu_program();
    for (int i = 0; i < 4; i++) begin
      mem[300 + 2 * i] = opa[i];
      mem[301 + 2 * i] = opb[i];
      mem[600 + i]     = fill_word(10'(600 + i));
      place_command(i, cmd(alu_ops[i], 600 + i, 300 + 2 * i, 301 + 2 * i));
    end
    place_command(4, cmd(op_halt, 0, 0, 0));
  endtask

  task automatic check_alu_results();
    for (int i = 0; i < 4; i++) begin
      check_word($sformatf("word %0d", 600 + i), alu_expected(i), mem[600 + i]);
    end
    check_pc("halt address", ADDR_W'(RESET_PC + 4), pc);
  endtask

  task automatic check_idle_outputs(input string when);
    check_word({when, " mem_req.valid"}, '0, DATA_W'(mem_req.valid));
    check_word({when, " halted"}, '0, DATA_W'(halted));
    check_pc({when, " pc"}, ADDR_W'(RESET_PC), pc);
  endtask

  // runs from time zero, inside the first reset
  task automatic reset_state_test();
    begin_test("reset_state");
    place_command(0, cmd(op_halt, 0, 0, 0));
    repeat (3) @(negedge clk);
    check_idle_outputs("in reset");
    while (rst) @(negedge clk);
    check_idle_outputs("after reset");
    run_to_halt();
    check_pc("halt address", ADDR_W'(RESET_PC), pc);
    end_test();
  endtask

  task automatic alu_ops_test();
    begin_test("alu_ops");
    for (int i = 0; i < 4; i++) begin
      opa[i] = random_bits(32);
      opb[i] = random_bits(32);
    end
    restart_core();
    load_alu_program();
    run_to_halt();
    check_alu_results();
    for (int i = 0; i < 4; i++) first_run[i] = mem[600 + i];
    end_test();
  endtask

  task automatic immediate_test();
    int                imms [3] = '{-5, 100, -256};
    logic [DATA_W-1:0] x;
    begin_test("immediate");
    x = random_bits(32);
    restart_core();
    mem[310] = x;
    for (int i = 0; i < 3; i++) begin
      mem[610 + i] = fill_word(10'(610 + i));
      place_command(i, cmd(op_addi, 610 + i, 310, imms[i]));
    end
    place_command(3, cmd(op_halt, 0, 0, 0));
    run_to_halt();
    for (int i = 0; i < 3; i++) begin
      check_word($sformatf("imm %0d", imms[i]), x + DATA_W'(imms[i]), mem[610 + i]);
    end
    check_pc("halt address", ADDR_W'(RESET_PC + 3), pc);
    end_test();
  endtask

  task automatic multiply_test();
    logic [DATA_W-1:0]   a [2];
    logic [DATA_W-1:0]   b [2];
    logic [2*DATA_W-1:0] p;
    begin_test("multiply");
    for (int i = 0; i < 2; i++) begin
      a[i] = random_bits(32);
      b[i] = random_bits(32);
    end
    restart_core();
    for (int i = 0; i < 2; i++) begin
      mem[320 + 2 * i] = a[i];
      mem[321 + 2 * i] = b[i];
      mem[620 + 2 * i] = fill_word(10'(620 + 2 * i));
      mem[621 + 2 * i] = fill_word(10'(621 + 2 * i));
      place_command(i, cmd(op_mul, 620 + 2 * i, 320 + 2 * i, 321 + 2 * i));
    end
    place_command(2, cmd(op_halt, 0, 0, 0));
    run_to_halt();
    for (int i = 0; i < 2; i++) begin
      p = {32'b0, a[i]} * {32'b0, b[i]};
      check_word($sformatf("low word %0d", i), p[31:0], mem[620 + 2 * i]);
      check_word($sformatf("high word %0d", i), p[63:32], mem[621 + 2 * i]);
    end
    check_pc("halt address", ADDR_W'(RESET_PC + 2), pc);
    end_test();
  endtask

  // 330 counts down, 331 holds one, 332 counts the passes
  task automatic branch_test();
    logic [DATA_W-1:0] start;
    begin_test("branch");
    start = random_bits(3) + 1;
    restart_core();
    mem[330] = start;
    mem[331] = 1;
    mem[332] = 0;
    place_command(0, cmd(op_add, 332, 332, 331));
    place_command(1, cmd(op_sub, 330, 330, 331));
    place_command(2, cmd(op_bnz, RESET_PC, 330, 0));
    place_command(3, cmd(op_halt, 0, 0, 0));
    run_to_halt();
    check_word("counter", '0, mem[330]);
    check_word("loop count", start, mem[332]);
    check_pc("halt address", ADDR_W'(RESET_PC + 3), pc);
    end_test();
  endtask

  task automatic backpressure_test();
    begin_test("backpressure");
    long_delays = 1'b1;
    restart_core();
    load_alu_program();
    run_to_halt();
    check_alu_results();
    for (int i = 0; i < 4; i++) begin
      check_word($sformatf("rerun word %0d", 600 + i), first_run[i], mem[600 + i]);
    end
    long_delays = 1'b0;
    end_test();
  endtask

/* testbench/tb_internal_bus.sv */
`timescale 1ns/1ps

module tb_internal_bus;
  import core_pkg::*;
  import mem_bus_pkg::*;

  localparam int          CREDITS  = 2;
  localparam int unsigned RESET_PC = 0;
  // commands executed over all six tests, countdown loop at its longest
  localparam int COMMANDS        = 1 + 5 + 4 + 3 + 25 + 5;
  localparam int WATCHDOG_CYCLES = (COMMANDS + 6) * 40;

  logic              clk;
  logic              rst;
  logic              restart;
  mem_req_t          mem_req;
  mem_rsp_t          mem_rsp;
  logic              halted;
  logic [ADDR_W-1:0] pc;

  logic [DATA_W-1:0] mem [0:1023];
  logic [31:0]       lfsr_state = 32'h45c4_26fa;
  logic              long_delays = 1'b0;
  string             test_name = "startup";
  int                errors;
  int                checks;
  int                tests;
  int                failed_tests;
  int                test_start_errors;
  int                outstanding;

  tb_clock_gen clock0 (
    .restart (restart),
    .clk     (clk),
    .rst     (rst)
  );

  internal_bus #(.CREDITS(CREDITS), .RESET_PC(RESET_PC)) dut0 (
    .clk     (clk),
    .rst     (rst),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp),
    .halted  (halted),
    .pc      (pc)
  );

  // galois form, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic logic [DATA_W-1:0] fill_word(input logic [9:0] a);
    return {a, ~a, a ^ 10'h2a5, 2'b10};
  endfunction

  task automatic fill_memory();
    for (int i = 0; i < 1024; i++) begin
      mem[i] = fill_word(10'(i));
    end
  endtask

  // register form layout; for addi the last field is the immediate
  function automatic logic [DATA_W-1:0] cmd(input opcode_t op, input int dst,
                                            input int src1, input int src0);
    return {op, 10'(dst), 9'(src1), 9'(src0)};
  endfunction

  task automatic place_command(input int idx, input logic [DATA_W-1:0] word);
    mem[ADDR_W'(RESET_PC) + ADDR_W'(idx)] = word;
  endtask

  task automatic check_word(input string what, input logic [DATA_W-1:0] expected,
                            input logic [DATA_W-1:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("ERR %s %s expected 0x%08h actual 0x%08h", test_name, what, expected, actual);
    end
  endtask

  task automatic check_pc(input string what, input logic [ADDR_W-1:0] expected,
                          input logic [ADDR_W-1:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("ERR %s %s expected 0x%03h actual 0x%03h", test_name, what, expected, actual);
    end
  endtask

  task automatic begin_test(input string name);
    test_name         = name;
    test_start_errors = errors;
    tests++;
  endtask

  task automatic end_test();
    int n;
    n = errors - test_start_errors;
    if (n != 0) failed_tests++;
    $display("%s: %0d errors", test_name, n);
  endtask

  // core goes back into reset for 16 cycles; memory may be loaded meanwhile
  task automatic restart_core();
    @(posedge clk);
    #1 restart = 1'b1;
    @(posedge clk);
    #1 restart = 1'b0;
  endtask

  task automatic run_to_halt();
    @(negedge clk);
    while (rst) @(negedge clk);
    while (!halted) @(negedge clk);
  endtask

  // in-order responses, each held back by an lfsr-chosen delay
  initial begin : memory_model
    logic [DATA_W-1:0] data_q[$];
    int                due_q[$];
    mem_req_t          req;
    logic              in_reset;
    int                now;
    int                delay;
    mem_rsp = '0;
    now     = 0;
    forever begin
      @(posedge clk);
      now++;
      req      = mem_req;
      in_reset = rst;
      if (in_reset) begin
        data_q.delete();
        due_q.delete();
      end else begin
        // the response on the bus was taken at this edge
        if (mem_rsp.valid) begin
          void'(data_q.pop_front());
          void'(due_q.pop_front());
        end
        if (req.valid) begin
          delay = long_delays ? int'(random_bits(4)) % 9 : int'(random_bits(2));
          if (req.write) mem[req.addr] = req.wdata;
          data_q.push_back(req.write ? '0 : mem[req.addr]);
          due_q.push_back(now + delay);
        end
      end
      #1;
      if (!in_reset && due_q.size() > 0 && due_q[0] <= now) begin
        mem_rsp.valid = 1'b1;
        mem_rsp.rdata = data_q[0];
      end else begin
        mem_rsp = '0;
      end
    end
  end

  always @(posedge clk) begin
    if (rst) begin
      outstanding = 0;
    end else begin
      outstanding = outstanding + int'(mem_req.valid) - int'(mem_rsp.valid);
      if (outstanding > CREDITS) begin
        errors++;
        $display("%s: %0d requests in flight, more than the credits", test_name, outstanding);
      end else if (outstanding < 0) begin
        errors++;
        $display("%s: memory answered more requests than were issued", test_name);
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("core never halted within %0d cycles", WATCHDOG_CYCLES);
    $display("test failed");
    $finish;
  end

  `include "tb_tests.svh"

  initial begin
    restart = 1'b0;
    fill_memory();
    reset_state_test();
    alu_ops_test();
    immediate_test();
    multiply_test();
    branch_test();
    backpressure_test();
    $display("summary: %0d tests, %0d with errors, %0d checks, %0d errors",
             tests, failed_tests, checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule
